/* build.f */
+incdir+logic
logic/game_pkg.sv
logic/frame_timer.sv
logic/regime_control.sv
logic/player_motion.sv
logic/enemy_patrol.sv
logic/pixel_mixer.sv
logic/game_top.sv
test/game_tb.sv

/* logic/enemy_patrol.sv */
`timescale 1ns/10ps

`include "game_consts.svh"

module enemy_patrol (
  input  logic             pixel_clk,
  input  logic             rst_n,
  input  logic             action_tick,
  output game_pkg::coord_t enemy_h
);

  logic        heading_left;
  logic [10:0] next_far_edge;  // Right side after a step right

  assign next_far_edge = {1'b0, enemy_h} + 11'd1 + 11'(`OBJ_SIZE);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      enemy_h      <= `ENEMY_H0;
      heading_left <= 1'b1;
    end else if (action_tick) begin
      if (heading_left) begin
        if (enemy_h == '0)
          heading_left <= 1'b0;  // Bounce off the left edge
        else
          enemy_h <= enemy_h - 10'd1;
      end else if (next_far_edge >= 11'(`H_LAST)) begin
        // Park against the right edge and turn back
        enemy_h      <= `H_LAST - `OBJ_SIZE;
        heading_left <= 1'b1;
      end else begin
        enemy_h <= enemy_h + 10'd1;
      end
    end
  end

endmodule

/* logic/frame_timer.sv */
`timescale 1ns/10ps

`include "game_consts.svh"

module frame_timer (
  input  logic             pixel_clk,
  input  logic             rst_n,
  input  logic [10:0]      h_coord,
  input  game_pkg::coord_t v_coord,
  output logic             action_tick
);

  logic       end_of_frame;  // One cycle after the last visible pixel
  logic [3:0] frames_cntr;

  // Last pixel of the active area seen on the previous cycle
  always_ff @(posedge pixel_clk) begin
    if (!rst_n)
      end_of_frame <= 1'b0;
    else
      end_of_frame <= (h_coord[9:0] == `H_LAST) && (v_coord == `V_LAST);
  end

  // Frame divider
  always_ff @(posedge pixel_clk) begin
    if (!rst_n)
      frames_cntr <= '0;
    else if (frames_cntr == `FRAMES_PER_ACTION)
      frames_cntr <= '0;  // Wraps one cycle after reaching the limit
    else if (end_of_frame)
      frames_cntr <= frames_cntr + 4'd1;
  end

  // Only the frame seen at count zero acts
  assign action_tick = end_of_frame && (frames_cntr == '0);

endmodule

/* logic/game_consts.svh */
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// Last visible pixel of the 800x600 frame
`define H_LAST            10'd799
`define V_LAST            10'd599

`define OBJ_SIZE          10'd128    // Side of both squares

// Frames in one action period
`define FRAMES_PER_ACTION 4'd2

// Sensor offset correction
`define ACCEL_X_CORR      8'd3
`define ACCEL_Y_CORR      8'd1

`define PLAYER_H0         10'd399    // Player start, screen centre
`define PLAYER_V0         10'd299
`define ENEMY_H0          10'd299
`define ENEMY_V           10'd355    // Enemy row never changes

// Flat colours, red in the low nibble
`define PLAYER_RGB        12'hF80
`define ENEMY_RGB         12'h0F4
`define BG_LEVEL          4'd8       // Channel level for a switch that is on

`endif

/* logic/game_pkg.sv */
package game_pkg;

  // Screen position, also the low bits of the pixel counters
  typedef logic [9:0] coord_t;

  // Accelerometer reading, two's complement
  typedef logic signed [7:0] accel_t;

  typedef logic [3:0] channel_t;  // One VGA colour channel

  // Control regimes, encodings kept from the board firmware
  typedef enum logic [1:0] {
    REGIME_ACCEL   = 2'b10,
    REGIME_BUTTONS = 2'b11
  } regime_t;

endpackage

/* logic/game_top.sv */
`timescale 1ns/10ps

module game_top (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               button_c,
  input  logic               button_u,
  input  logic               button_d,
  input  logic               button_r,
  input  logic               button_l,
  input  game_pkg::accel_t   accel_data_x,
  input  game_pkg::accel_t   accel_data_y,
  output game_pkg::accel_t   accel_x_end_of_frame,
  output game_pkg::accel_t   accel_y_end_of_frame,
  input  logic [10:0]        h_coord,
  input  game_pkg::coord_t   v_coord,
  output game_pkg::channel_t red,
  output game_pkg::channel_t green,
  output game_pkg::channel_t blue,
  input  logic [2:0]         SW,
  output logic [1:0]         demo_regime_status
);

  import game_pkg::*;

  logic    action_tick;  // Once per action period
  regime_t regime;
  coord_t  player_h;
  coord_t  player_v;
  coord_t  enemy_h;

  frame_timer u_frame_timer (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .h_coord     (h_coord),
    .v_coord     (v_coord),
    .action_tick (action_tick)
  );

  regime_control u_regime_control (
    .pixel_clk          (pixel_clk),
    .rst_n              (rst_n),
    .button_c           (button_c),
    .regime             (regime),
    .demo_regime_status (demo_regime_status)
  );

  player_motion u_player_motion (
    .pixel_clk            (pixel_clk),
    .rst_n                (rst_n),
    .action_tick          (action_tick),
    .regime               (regime),
    .button_u             (button_u),
    .button_d             (button_d),
    .button_l             (button_l),
    .button_r             (button_r),
    .accel_data_x         (accel_data_x),
    .accel_data_y         (accel_data_y),
    .accel_x_end_of_frame (accel_x_end_of_frame),
    .accel_y_end_of_frame (accel_y_end_of_frame),
    .player_h             (player_h),
    .player_v             (player_v)
  );

  enemy_patrol u_enemy_patrol (
    .pixel_clk   (pixel_clk),
    .rst_n       (rst_n),
    .action_tick (action_tick),
    .enemy_h     (enemy_h)
  );

  pixel_mixer u_pixel_mixer (
    .h_coord  (h_coord),
    .v_coord  (v_coord),
    .SW       (SW),
    .player_h (player_h),
    .player_v (player_v),
    .enemy_h  (enemy_h),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

endmodule

/* logic/pixel_mixer.sv */
`timescale 1ns/10ps

`include "game_consts.svh"

module pixel_mixer (
  input  logic [10:0]        h_coord,
  input  game_pkg::coord_t   v_coord,
  input  logic [2:0]         SW,
  input  game_pkg::coord_t   player_h,
  input  game_pkg::coord_t   player_v,
  input  game_pkg::coord_t   enemy_h,
  output game_pkg::channel_t red,
  output game_pkg::channel_t green,
  output game_pkg::channel_t blue
);

  import game_pkg::*;

  coord_t      pix_h;
  logic        on_player;
  logic        on_enemy;
  logic [11:0] obj_rgb;

  // Square test, both edges inclusive
  function automatic logic in_square(coord_t h, coord_t v, coord_t left, coord_t top);
    logic [10:0] right;
    logic [10:0] bottom;
    right  = {1'b0, left} + 11'(`OBJ_SIZE);
    bottom = {1'b0, top} + 11'(`OBJ_SIZE);
    return (h >= left) && ({1'b0, h} <= right) &&
           (v >= top) && ({1'b0, v} <= bottom);
  endfunction

  assign pix_h     = h_coord[9:0];
  assign on_player = in_square(pix_h, v_coord, player_h, player_v);
  assign on_enemy  = in_square(pix_h, v_coord, enemy_h, `ENEMY_V);

  always_comb begin
    // Player is drawn over the enemy
    obj_rgb = `ENEMY_RGB;
    if (on_player)
      obj_rgb = `PLAYER_RGB;

    if (on_player || on_enemy) begin
      red   = obj_rgb[3:0];
      green = obj_rgb[7:4];
      blue  = obj_rgb[11:8];
    end else begin
      // Background picked by the switches
      red   = SW[0] ? `BG_LEVEL : 4'd0;
      green = SW[1] ? `BG_LEVEL : 4'd0;
      blue  = SW[2] ? `BG_LEVEL : 4'd0;
    end
  end

endmodule

/* logic/player_motion.sv */
`timescale 1ns/10ps

`include "game_consts.svh"

module player_motion (
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  logic              action_tick,
  input  game_pkg::regime_t regime,
  input  logic              button_u,
  input  logic              button_d,
  input  logic              button_l,
  input  logic              button_r,
  input  game_pkg::accel_t  accel_data_x,
  input  game_pkg::accel_t  accel_data_y,
  output game_pkg::accel_t  accel_x_end_of_frame,
  output game_pkg::accel_t  accel_y_end_of_frame,
  output game_pkg::coord_t  player_h,
  output game_pkg::coord_t  player_v
);

  import game_pkg::*;

  accel_t accel_x_corr;
  accel_t accel_y_corr;
  logic   go_left;
  logic   go_right;
  logic   go_up;
  logic   go_down;

  // One pixel towards zero, held at the edge
  function automatic coord_t step_back(coord_t pos);
    if (pos == '0)
      return '0;
    else
      return pos - 10'd1;
  endfunction

  // One pixel away from zero, the far side of the square stops at last
  function automatic coord_t step_fwd(coord_t pos, coord_t last);
    logic [10:0] far_edge;
    far_edge = {1'b0, pos} + 11'd1 + 11'(`OBJ_SIZE);
    if (far_edge >= {1'b0, last})
      return last - `OBJ_SIZE;
    else
      return pos + 10'd1;
  endfunction

  assign accel_x_corr = accel_data_x + `ACCEL_X_CORR;
  assign accel_y_corr = accel_data_y + `ACCEL_Y_CORR;

  // Direction requests for the current regime
  always_comb begin
    go_left  = 1'b0;
    go_right = 1'b0;
    go_up    = 1'b0;
    go_down  = 1'b0;
    if (regime == REGIME_BUTTONS) begin
      go_left  = button_l;
      go_right = button_r;
      go_up    = button_u;
      go_down  = button_d;
    end else if (regime == REGIME_ACCEL) begin
      // Board tilt, y steers horizontally and x vertically
      go_left  = !accel_y_corr[7] && (accel_y_corr != '0);
      go_right = accel_y_corr[7];
      go_up    = accel_x_corr[7];
      go_down  = !accel_x_corr[7] && (accel_x_corr != '0);
    end
  end

  // Sensor values used for this action period
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      accel_x_end_of_frame <= '0;
      accel_y_end_of_frame <= '0;
    end else if (action_tick) begin
      accel_x_end_of_frame <= accel_x_corr;
      accel_y_end_of_frame <= accel_y_corr;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      player_h <= `PLAYER_H0;
      player_v <= `PLAYER_V0;
    end else if (action_tick) begin
      // Left wins over right
      if (go_left)
        player_h <= step_back(player_h);
      else if (go_right)
        player_h <= step_fwd(player_h, `H_LAST);

      // Up wins over down
      if (go_up)
        player_v <= step_back(player_v);
      else if (go_down)
        player_v <= step_fwd(player_v, `V_LAST);
    end
  end

endmodule

/* logic/regime_control.sv */
`timescale 1ns/10ps

module regime_control (
  input  logic              pixel_clk,
  input  logic              rst_n,
  input  logic              button_c,
  output game_pkg::regime_t regime,
  output logic [1:0]        demo_regime_status
);

  import game_pkg::*;

  // Every cycle with the button high flips the regime
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      regime <= REGIME_BUTTONS;
    end else if (button_c) begin
      if (regime == REGIME_BUTTONS)
        regime <= REGIME_ACCEL;
      else
        regime <= REGIME_BUTTONS;  // Also recovers from a stray encoding
    end
  end

  assign demo_regime_status = regime;  // Raw encoding for the LEDs

endmodule

/* test/game_golden.txt */
# F count up down left right accel_x accel_y sw | C | P h v red green blue
# A accel_x_out accel_y_out | R regime     (count, h and v decimal, the rest hex)
P 450 350 0 8 f
P 320 400 4 f 0
R 3
A 00 00
F 2 0 0 0 0 00 00 5
P 10 10 8 0 8
P 298 400 4 f 0
P 297 400 8 0 8
P 399 355 0 8 f
F 200 1 0 1 0 00 00 5
P 299 199 0 8 f
P 197 400 8 0 8
F 600 1 0 1 0 00 00 5
P 0 0 0 8 f
P 129 128 8 0 8
P 101 400 4 f 0
P 100 400 8 0 8
F 20 0 0 0 1 00 00 5
F 10 0 0 1 1 00 00 5
P 5 0 0 8 f
P 4 0 8 0 8
F 100 0 1 0 1 00 00 2
P 183 178 0 8 f
P 184 178 0 8 0
C
R 2
C
R 3
C
R 2
F 20 0 0 0 0 f0 05 5
A f3 06
P 45 40 0 8 f
P 44 40 8 0 8
F 10 0 0 0 0 fd 05 5
A 00 06
P 40 39 8 0 8
P 40 40 0 8 f
F 1000 0 0 1 0 fd ff 5
A 00 00
P 40 40 0 8 f
P 661 400 4 f 0
P 660 400 8 0 8
P 789 400 4 f 0
P 790 400 8 0 8

/* test/game_tb.sv */
`timescale 1ns/10ps

`include "game_consts.svh"

module game_tb;

  import game_pkg::*;

  localparam int MAX_CMDS     = 128;
  localparam int RESET_CYCLES = 16;

  logic        pixel_clk;
  logic        rst_n;
  logic        button_c, button_u, button_d, button_r, button_l;
  accel_t      accel_data_x;
  accel_t      accel_data_y;
  accel_t      accel_x_end_of_frame;
  accel_t      accel_y_end_of_frame;
  logic [10:0] h_coord;
  coord_t      v_coord;
  channel_t    red, green, blue;
  logic [2:0]  SW;
  logic [1:0]  demo_regime_status;

  byte         cmd_list [MAX_CMDS];
  int          arg_list [MAX_CMDS][8];  // Fields of each golden command
  int          num_cmds;
  int          cycle_limit;
  int          cycle_count;

  game_top DUT (.*);

  initial begin
    pixel_clk = 1'b0;
    forever #50 pixel_clk = ~pixel_clk;
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped");
  endtask

  // Watchdog sized from the golden commands
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge pixel_clk);
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
        stop_with_failure($sformatf("Run exceeded its limit of %0d cycles", cycle_limit));
    end
  end

  task automatic check_pixel(input string name, input channel_t got, input channel_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_accel(input string name, input accel_t got, input accel_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_regime(input regime_t got, input regime_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("FAIL demo_regime_status: got 0x%h, expected 0x%h",
                                  got, exp));
  endtask

  task automatic load_golden();
    int               fd;
    int               code;
    byte              cmd;
    logic             ok;
    logic [8*256-1:0] rest;
    fd = $fopen("test/game_golden.txt", "r");
    if (fd == 0)
      stop_with_failure("Cannot open the golden file test/game_golden.txt");
    num_cmds    = 0;
    cycle_limit = RESET_CYCLES + 100;
    while ($fscanf(fd, " %c", cmd) == 1) begin
      if (cmd == "#") begin
        code = $fgets(rest, fd);  // Skip the comment
      end else begin
        if (num_cmds == MAX_CMDS)
          stop_with_failure("The golden file holds more commands than the testbench stores");
        case (cmd)
          "F": begin
            code = $fscanf(fd, "%d %d %d %d %d %h %h %h",
                           arg_list[num_cmds][0], arg_list[num_cmds][1],
                           arg_list[num_cmds][2], arg_list[num_cmds][3],
                           arg_list[num_cmds][4], arg_list[num_cmds][5],
                           arg_list[num_cmds][6], arg_list[num_cmds][7]);
            ok = (code == 8);
            cycle_limit += 6 * arg_list[num_cmds][0];  // Six cycles per frame
          end
          "P": begin
            code = $fscanf(fd, "%d %d %h %h %h",
                           arg_list[num_cmds][0], arg_list[num_cmds][1],
                           arg_list[num_cmds][2], arg_list[num_cmds][3],
                           arg_list[num_cmds][4]);
            ok = (code == 5);
            cycle_limit += 2;
          end
          "A": begin
            code = $fscanf(fd, "%h %h", arg_list[num_cmds][0], arg_list[num_cmds][1]);
            ok = (code == 2);
            cycle_limit += 1;
          end
          "R": begin
            code = $fscanf(fd, "%h", arg_list[num_cmds][0]);
            ok = (code == 1);
            cycle_limit += 1;
          end
          "C": begin
            ok = 1'b1;
            cycle_limit += 2;
          end
          default: ok = 1'b0;
        endcase
        if (!ok)
          stop_with_failure($sformatf("Golden command %0d (%c) could not be read",
                                      num_cmds + 1, cmd));
        cmd_list[num_cmds] = cmd;
        num_cmds++;
      end
    end
    $fclose(fd);
    if (num_cmds == 0)
      stop_with_failure("The golden file holds no commands");
  endtask

  // Parks the counters, then passes the last visible pixel once
  task automatic run_frame(input int idx);
    @(posedge pixel_clk);
    button_u     <= (arg_list[idx][1] != 0);
    button_d     <= (arg_list[idx][2] != 0);
    button_l     <= (arg_list[idx][3] != 0);
    button_r     <= (arg_list[idx][4] != 0);
    accel_data_x <= accel_t'(arg_list[idx][5]);
    accel_data_y <= accel_t'(arg_list[idx][6]);
    SW           <= 3'(arg_list[idx][7]);
    h_coord      <= '0;
    v_coord      <= '0;
    repeat (2) @(posedge pixel_clk);
    h_coord <= 11'(`H_LAST);
    v_coord <= `V_LAST;
    @(posedge pixel_clk);
    h_coord <= '0;
    v_coord <= '0;
    repeat (2) @(posedge pixel_clk);  // end_of_frame, then the tick edge
  endtask

  task automatic pulse_button_c();
    @(posedge pixel_clk);
    button_c <= 1'b1;
    @(posedge pixel_clk);
    button_c <= 1'b0;
  endtask

  task automatic probe_pixel(input int idx);
    @(posedge pixel_clk);
    h_coord <= 11'(arg_list[idx][0]);
    v_coord <= coord_t'(arg_list[idx][1]);
    @(posedge pixel_clk);
    @(negedge pixel_clk);
    check_pixel("red", red, channel_t'(arg_list[idx][2]));
    check_pixel("green", green, channel_t'(arg_list[idx][3]));
    check_pixel("blue", blue, channel_t'(arg_list[idx][4]));
  endtask

  initial begin
    rst_n        = 1'b0;
    button_c     = 1'b0;
    button_u     = 1'b0;
    button_d     = 1'b0;
    button_r     = 1'b0;
    button_l     = 1'b0;
    accel_data_x = '0;
    accel_data_y = '0;
    h_coord      = '0;
    v_coord      = '0;
    SW           = '0;
    load_golden();
    repeat (RESET_CYCLES) @(posedge pixel_clk);
    rst_n <= 1'b1;
    for (int i = 0; i < num_cmds; i++) begin
      case (cmd_list[i])
        "F": repeat (arg_list[i][0]) run_frame(i);
        "C": pulse_button_c();
        "P": probe_pixel(i);
        "A": begin
          @(negedge pixel_clk);
          check_accel("accel_x_end_of_frame", accel_x_end_of_frame, accel_t'(arg_list[i][0]));
          check_accel("accel_y_end_of_frame", accel_y_end_of_frame, accel_t'(arg_list[i][1]));
        end
        default: begin
          @(negedge pixel_clk);
          check_regime(regime_t'(demo_regime_status), regime_t'(arg_list[i][0]));
        end
      endcase
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule
